//--- common/ctrl_pkg.sv
// Controller-side definitions; only the trap and flush targets of this sequencer are encoded here

package ctrl_pkg;

  ////////////////////
  // Program counter targets
  ////////////////////

  // Target of a program counter set issued by the event arbiter
  // PC_NONE is the idle value and appears whenever no set is issued
  // PC_TRAP_NMI jumps to the NMI handler after a bus error
  // PC_FENCEI restarts fetch behind the fence.i once the flush has completed
  typedef enum logic [1:0] {
    PC_NONE     = 2'b00,
    PC_TRAP_NMI = 2'b01,
    PC_FENCEI   = 2'b10
  } pc_mux_e;

endpackage

//--- common/obi_pkg.sv
// Bus-side definitions; the count type is 2 bits wide, so at most 3 transactions may be outstanding

package obi_pkg;

  ////////////////////
  // Outstanding transactions
  ////////////////////

  // Number of transactions the load/store unit may have in flight by default
  // The top level passes it on as MAX_OUTSTANDING
  parameter int MAX_OUTSTANDING_DEF = 2;

  // Count of accepted transactions that still wait for their response
  // Two bits cover depths of 1, 2 and 3
  typedef logic [1:0] outstanding_cnt_t;

endpackage

//--- common/txn_event_if.sv
// All signals are driven by the tracker; err_valid is a single-cycle pulse, the rest are levels
`timescale 1ns/100ps

interface txn_event_if;

  // Pulse in the cycle after an error response was seen on the bus
  logic                      err_valid;

  // Write flag of the transaction whose response carried the error
  // Only meaningful while err_valid is high
  logic                      err_is_write;

  // Registered number of transactions that still wait for a response
  obi_pkg::outstanding_cnt_t outstanding_cnt;

  // High when nothing is outstanding and nothing is being accepted
  logic                      bus_idle;

  ////////////////////
  // Views
  ////////////////////

  // The tracker owns every signal
  modport tracker (output err_valid, err_is_write, outstanding_cnt, bus_idle);

  // The NMI latch only cares about error events
  modport latch (input err_valid, err_is_write);

  // The arbiter only cares whether the load/store unit is quiet
  modport arb (input outstanding_cnt, bus_idle);

endinterface

//--- controller/ctrl_event_arb.sv
// The NMI wins only before a flush request is raised; a raised request always completes its handshake
`timescale 1ns/100ps

module ctrl_event_arb (
  input  logic              clk,
  input  logic              rst_n,
  txn_event_if.arb          evt,
  input  logic              nmi_pending_i,
  input  logic              lsu_in_wb_i,
  input  logic              fencei_in_wb_i,
  input  logic              fencei_flush_ack_i,
  output logic              nmi_taken_o,
  output logic              pc_set_o,
  output logic              fencei_flush_req_o,
  output ctrl_pkg::pc_mux_e pc_mux_o
);

  // Flush handshake states
  typedef enum logic [1:0] {
    ARB_IDLE       = 2'b00,
    ARB_FLUSH_REQ  = 2'b01,
    ARB_FLUSH_DONE = 2'b10
  } arb_state_e;

  arb_state_e        state_q;
  arb_state_e        state_d;

  // Registered program counter event
  logic              pc_set_q;
  logic              pc_set_d;
  ctrl_pkg::pc_mux_e pc_mux_q;
  ctrl_pkg::pc_mux_e pc_mux_d;

  // Decision terms
  logic              lsu_quiet;
  logic              nmi_allowed;
  logic              flush_start;
  logic              flush_meet;

  ////////////////////
  // Decisions
  ////////////////////

  // Quiet means the count has drained and no new access is accepted right now
  assign lsu_quiet = evt.bus_idle && (evt.outstanding_cnt == '0);

  // No NMI in the middle of a handshake, and none right behind another set
  // The second rule also keeps a still pending NMI from firing twice
  assign nmi_allowed = nmi_pending_i && lsu_quiet && !lsu_in_wb_i &&
                       (state_q != ARB_FLUSH_REQ) && !pc_set_q;

  // A pending NMI holds off the flush, which gives the trap its priority
  assign flush_start = (state_q == ARB_IDLE) && fencei_in_wb_i && lsu_quiet && !nmi_pending_i;

  // The request is high throughout ARB_FLUSH_REQ, so an ack elsewhere is ignored
  assign flush_meet  = (state_q == ARB_FLUSH_REQ) && fencei_flush_ack_i;

  ////////////////////
  // Flush FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ARB_IDLE: begin
        if (flush_start) begin
          state_d = ARB_FLUSH_REQ;
        end
      end
      ARB_FLUSH_REQ: begin
        if (flush_meet) begin
          state_d = ARB_FLUSH_DONE;
        end
      end
      ARB_FLUSH_DONE: begin
        // Wait for the fence.i to leave WB so it does not flush a second time
        if (!fencei_in_wb_i) begin
          state_d = ARB_IDLE;
        end
      end
      default: state_d = ARB_IDLE;
    endcase
  end

  // Both set sources are exclusive because NMIs are blocked in ARB_FLUSH_REQ
  always_comb begin
    pc_set_d = 1'b0;
    pc_mux_d = ctrl_pkg::PC_NONE;
    if (nmi_allowed) begin
      pc_set_d = 1'b1;
      pc_mux_d = ctrl_pkg::PC_TRAP_NMI;
    end else if (flush_meet) begin
      pc_set_d = 1'b1;
      pc_mux_d = ctrl_pkg::PC_FENCEI;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= ARB_IDLE;
      pc_set_q <= 1'b0;
      pc_mux_q <= ctrl_pkg::PC_NONE;
    end else begin
      state_q  <= state_d;
      pc_set_q <= pc_set_d;
      pc_mux_q <= pc_mux_d;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign pc_set_o           = pc_set_q;
  assign pc_mux_o           = pc_mux_q;
  // The trap pulse doubles as the release of the NMI latch
  assign nmi_taken_o        = pc_set_q && (pc_mux_q == ctrl_pkg::PC_TRAP_NMI);
  assign fencei_flush_req_o = (state_q == ARB_FLUSH_REQ);

endmodule

//--- controller/nmi_latch.sv
// Keeps only the first bus error since the last NMI trap; later errors are dropped until it is taken
`timescale 1ns/100ps

module nmi_latch (
  input  logic       clk,
  input  logic       rst_n,
  txn_event_if.latch evt,
  input  logic       nmi_taken_i,
  output logic       nmi_pending_o,
  output logic       nmi_is_store_o
);

  // Sticky record of the pending NMI
  logic pending_q;
  logic is_store_q;

  // A new error is recorded only while nothing is pending
  logic capture;

  ////////////////////
  // Error capture
  ////////////////////

  // The taken pulse arrives while pending is still high, so an error in that
  // same cycle is also dropped
  assign capture = evt.err_valid && !pending_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q  <= 1'b0;
      is_store_q <= 1'b0;
    end else begin
      if (nmi_taken_i) begin
        // The trap has been issued, so the record is released
        pending_q <= 1'b0;
      end else if (capture) begin
        pending_q  <= 1'b1;
        // Store or load is fixed by the first error only
        is_store_q <= evt.err_is_write;
      end
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign nmi_pending_o  = pending_q;
  assign nmi_is_store_o = is_store_q;

endmodule

//--- controller/obi_txn_tracker.sv
// Responses must return in order and the master must never exceed MAX_OUTSTANDING (at most 3)
`timescale 1ns/100ps

module obi_txn_tracker #(
  parameter int MAX_OUTSTANDING = obi_pkg::MAX_OUTSTANDING_DEF
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         obi_req_i,
  input  logic         obi_gnt_i,
  input  logic         obi_we_i,
  input  logic         obi_rvalid_i,
  input  logic         obi_err_i,
  txn_event_if.tracker evt
);

  // Handshake strobes of the bus
  logic                       accept;
  logic                       resp;

  // Outstanding count and the slot the next accepted flag is written to
  obi_pkg::outstanding_cnt_t  cnt_q;
  obi_pkg::outstanding_cnt_t  cnt_d;
  obi_pkg::outstanding_cnt_t  wr_idx;

  // In-order queue of write flags, oldest entry in bit 0
  logic [MAX_OUTSTANDING-1:0] we_q;
  logic [MAX_OUTSTANDING-1:0] we_d;

  // Registered error event
  logic                       err_valid_q;
  logic                       err_is_write_q;

  // A transaction is taken only when request and grant meet
  // A low grant stalls the master and nothing is recorded
  assign accept = obi_req_i && obi_gnt_i;
  assign resp   = obi_rvalid_i;

  ////////////////////
  // Outstanding count
  ////////////////////

  // Acceptance and response in the same cycle cancel out
  always_comb begin
    cnt_d = cnt_q;
    case ({accept, resp})
      2'b10:   cnt_d = cnt_q + obi_pkg::outstanding_cnt_t'(1);
      2'b01:   cnt_d = cnt_q - obi_pkg::outstanding_cnt_t'(1);
      default: cnt_d = cnt_q;
    endcase
  end

  ////////////////////
  // Write flag queue
  ////////////////////

  // When a response pops the oldest entry in the same cycle, the new flag lands one slot lower
  assign wr_idx = resp ? (cnt_q - obi_pkg::outstanding_cnt_t'(1)) : cnt_q;

  always_comb begin
    we_d = we_q;
    // Responses come back in order, so a pop always drops bit 0
    if (resp) begin
      we_d = we_q >> 1;
    end
    for (int i = 0; i < MAX_OUTSTANDING; i++) begin
      if (accept && (wr_idx == obi_pkg::outstanding_cnt_t'(i))) begin
        we_d[i] = obi_we_i;
      end
    end
  end

  // Only the slots below the outstanding count hold live flags
  always_ff @(posedge clk) begin
    we_q <= we_d;
  end

  // The popped flag belongs to the response in this cycle
  always_ff @(posedge clk) begin
    if (resp) begin
      err_is_write_q <= we_q[0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q       <= '0;
      err_valid_q <= 1'b0;
    end else begin
      cnt_q       <= cnt_d;
      // Every error response gives a pulse, and filtering is left to the latch
      err_valid_q <= resp && obi_err_i;
    end
  end

  ////////////////////
  // Event outputs
  ////////////////////

  assign evt.err_valid       = err_valid_q;
  assign evt.err_is_write    = err_is_write_q;
  assign evt.outstanding_cnt = cnt_q;
  // An acceptance in this cycle already makes the bus busy
  assign evt.bus_idle        = (cnt_q == '0) && !accept;

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f src.f --top-module tb_lsu_nmi_ctrl

# The run may stop early on an assertion, so its status is kept and the log decides
status=0
./obj_dir/Vtb_lsu_nmi_ctrl > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "=== PASS ===" sim.log; then
  exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1

//--- source/lsu_nmi_ctrl_top.sv
// MAX_OUTSTANDING may be 1 to 3 and must match the bus master; all outputs are registered
`timescale 1ns/100ps

module lsu_nmi_ctrl_top #(
  parameter int MAX_OUTSTANDING = obi_pkg::MAX_OUTSTANDING_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  // Bus traffic of the load/store unit
  input  logic              obi_req_i,
  input  logic              obi_gnt_i,
  input  logic              obi_we_i,
  input  logic              obi_rvalid_i,
  input  logic              obi_err_i,
  // Pipeline status
  input  logic              lsu_in_wb_i,
  input  logic              fencei_in_wb_i,
  // Flush handshake
  input  logic              fencei_flush_ack_i,
  output logic              fencei_flush_req_o,
  // Program counter event and NMI status
  output logic              pc_set_o,
  output ctrl_pkg::pc_mux_e pc_mux_o,
  output logic              nmi_pending_o,
  output logic              nmi_is_store_o
);

  // Release of the NMI latch by the arbiter
  logic nmi_taken;

  // Bus events from the tracker to the later stages
  txn_event_if evt_if ();

  // Stage 1 turns bus strobes into error events and idleness
  obi_txn_tracker #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) obi_txn_tracker_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .obi_req_i    (obi_req_i),
    .obi_gnt_i    (obi_gnt_i),
    .obi_we_i     (obi_we_i),
    .obi_rvalid_i (obi_rvalid_i),
    .obi_err_i    (obi_err_i),
    .evt          (evt_if.tracker)
  );

  // Stage 2 holds the first error as a pending NMI
  nmi_latch nmi_latch_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .evt            (evt_if.latch),
    .nmi_taken_i    (nmi_taken),
    .nmi_pending_o  (nmi_pending_o),
    .nmi_is_store_o (nmi_is_store_o)
  );

  // Stage 3 picks between the trap and the fence.i flush
  ctrl_event_arb ctrl_event_arb_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .evt                (evt_if.arb),
    .nmi_pending_i      (nmi_pending_o),
    .lsu_in_wb_i        (lsu_in_wb_i),
    .fencei_in_wb_i     (fencei_in_wb_i),
    .fencei_flush_ack_i (fencei_flush_ack_i),
    .nmi_taken_o        (nmi_taken),
    .pc_set_o           (pc_set_o),
    .fencei_flush_req_o (fencei_flush_req_o),
    .pc_mux_o           (pc_mux_o)
  );

endmodule

//--- src.f
+incdir+tb
common/obi_pkg.sv
common/ctrl_pkg.sv
common/txn_event_if.sv
controller/obi_txn_tracker.sv
controller/nmi_latch.sv
controller/ctrl_event_arb.sv
source/lsu_nmi_ctrl_top.sv
tb/lsu_nmi_ctrl_asserts.sv
tb/tb_lsu_nmi_ctrl.sv

//--- tb/lsu_nmi_ctrl_asserts.sv
// Sees only the top-level ports and the tracker's bus_idle; all checks are off while rst_n is low
`timescale 1ns/100ps

module lsu_nmi_ctrl_asserts (
  input logic              clk,
  input logic              rst_n,
  input logic              fencei_in_wb_i,
  input logic              fencei_flush_ack_i,
  input logic              fencei_flush_req_i,
  input logic              pc_set_i,
  input ctrl_pkg::pc_mux_e pc_mux_i,
  input logic              bus_idle_i
);

  ////////////////////
  // Flush handshake
  ////////////////////

  // The request is registered, so the fence.i had to be in WB one cycle earlier
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(fencei_flush_req_i) |-> $past(fencei_in_wb_i))
    else $error("flush request raised without fence.i in WB");

  // A request may only drop after it met an ack
  assert property (@(posedge clk) disable iff (!rst_n)
    $fell(fencei_flush_req_i) |-> $past(fencei_flush_ack_i))
    else $error("flush request dropped without an ack");

  ////////////////////
  // Program counter events
  ////////////////////

  assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i |=> !pc_set_i)
    else $error("pc_set_o held for more than one cycle");

  // The trap decision was taken in the cycle before the pulse
  assert property (@(posedge clk) disable iff (!rst_n)
    (pc_set_i && (pc_mux_i == ctrl_pkg::PC_TRAP_NMI)) |-> $past(bus_idle_i))
    else $error("NMI trap issued while the bus was busy");

endmodule

bind lsu_nmi_ctrl_top lsu_nmi_ctrl_asserts lsu_nmi_ctrl_asserts_i (
  .clk                (clk),
  .rst_n              (rst_n),
  .fencei_in_wb_i     (fencei_in_wb_i),
  .fencei_flush_ack_i (fencei_flush_ack_i),
  .fencei_flush_req_i (fencei_flush_req_o),
  .pc_set_i           (pc_set_o),
  .pc_mux_i           (pc_mux_o),
  .bus_idle_i         (evt_if.bus_idle)
);

//--- tb/tb_lsu_nmi_ctrl_tasks.svh
// Runs inside tb_lsu_nmi_ctrl on its signals; inputs change 1 ns after the rising edge
`ifndef TB_LSU_NMI_CTRL_TASKS_SVH
`define TB_LSU_NMI_CTRL_TASKS_SVH

  // Events a test can wait for
  typedef enum {EV_PC_SET, EV_FLUSH_REQ, EV_NMI_PENDING} wait_event_e;

  ////////////////////
  // Drivers
  ////////////////////

  task automatic idle_inputs();
    obi_req          = 1'b0;
    obi_gnt          = 1'b0;
    obi_we           = 1'b0;
    obi_rvalid       = 1'b0;
    obi_err          = 1'b0;
    lsu_in_wb        = 1'b0;
    fencei_in_wb     = 1'b0;
    fencei_flush_ack = 1'b0;
  endtask

  // Registered outputs are settled here, and new inputs go in from here
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic bus_accept(input logic we);
    obi_req = 1'b1;
    obi_gnt = 1'b1;
    obi_we  = we;
    step();
    obi_req = 1'b0;
    obi_gnt = 1'b0;
    obi_we  = 1'b0;
  endtask

  task automatic bus_respond(input logic err);
    obi_rvalid = 1'b1;
    obi_err    = err;
    step();
    obi_rvalid = 1'b0;
    obi_err    = 1'b0;
  endtask

  ////////////////////
  // Compares and waits
  ////////////////////

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0d ns: %s is %0b, expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic check_pc_mux(input ctrl_pkg::pc_mux_e got, input ctrl_pkg::pc_mux_e exp,
                              input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0d ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic wait_for(input wait_event_e ev, input string what, output logic seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < WAIT_LIMIT) begin
      step();
      case (ev)
        EV_PC_SET:    seen = pc_set;
        EV_FLUSH_REQ: seen = fencei_flush_req;
        default:      seen = nmi_pending;
      endcase
      n++;
    end
    if (!seen) begin
      timeout_cnt++;
      $display("Timeout after %0d cycles while waiting for %s", WAIT_LIMIT, what);
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_reset_values();
    check_bit(pc_set, 1'b0, "pc_set_o in reset");
    check_bit(fencei_flush_req, 1'b0, "fencei_flush_req_o in reset");
    check_bit(nmi_pending, 1'b0, "nmi_pending_o in reset");
    check_pc_mux(pc_mux, ctrl_pkg::PC_NONE, "pc_mux_o in reset");
  endtask

  task automatic test_load_error();
    logic seen;
    // The load stays in WB, which holds the trap off
    lsu_in_wb = 1'b1;
    bus_accept(1'b0);
    bus_respond(1'b1);
    wait_for(EV_NMI_PENDING, "NMI pending after load error", seen);
    check_bit(nmi_is_store, 1'b0, "nmi_is_store_o after load error");
    repeat (3) begin
      step();
      check_bit(pc_set, 1'b0, "pc_set_o while load in WB");
    end
    lsu_in_wb = 1'b0;
    wait_for(EV_PC_SET, "NMI trap after load error", seen);
    check_pc_mux(pc_mux, ctrl_pkg::PC_TRAP_NMI, "pc_mux_o on load error trap");
    step();
    check_bit(nmi_pending, 1'b0, "nmi_pending_o after trap");
    check_bit(pc_set, 1'b0, "pc_set_o after trap");
  endtask

  task automatic test_store_first();
    logic seen;
    lsu_in_wb = 1'b1;
    bus_accept(1'b1);
    bus_accept(1'b0);
    // In-order responses, so the store is the one that fails
    bus_respond(1'b1);
    bus_respond(1'b0);
    wait_for(EV_NMI_PENDING, "NMI pending after store error", seen);
    check_bit(nmi_is_store, 1'b1, "nmi_is_store_o for oldest store");
    lsu_in_wb = 1'b0;
    wait_for(EV_PC_SET, "NMI trap after store error", seen);
    check_pc_mux(pc_mux, ctrl_pkg::PC_TRAP_NMI, "pc_mux_o on store error trap");
    step();
    check_bit(nmi_pending, 1'b0, "nmi_pending_o after store trap");
  endtask

  task automatic test_second_error();
    logic seen;
    int   extra;
    extra     = 0;
    lsu_in_wb = 1'b1;
    bus_accept(1'b0);
    bus_accept(1'b1);
    bus_respond(1'b1);
    bus_respond(1'b1);
    wait_for(EV_NMI_PENDING, "NMI pending after two errors", seen);
    step();
    step();
    // The failing store came second and must not overwrite the load
    check_bit(nmi_is_store, 1'b0, "nmi_is_store_o after second error");
    lsu_in_wb = 1'b0;
    wait_for(EV_PC_SET, "NMI trap after two errors", seen);
    check_pc_mux(pc_mux, ctrl_pkg::PC_TRAP_NMI, "pc_mux_o after two errors");
    repeat (10) begin
      step();
      if (pc_set) begin
        extra++;
      end
    end
    check_bit(extra != 0, 1'b0, "extra pc_set_o after two errors");
    check_bit(nmi_pending, 1'b0, "nmi_pending_o after two errors");
  endtask

  task automatic test_fencei_wait();
    logic seen;
    int   hold;
    bus_accept(1'b0);
    fencei_in_wb = 1'b1;
    // A stray ack with no request must change nothing
    fencei_flush_ack = 1'b1;
    repeat (4) begin
      step();
      fencei_flush_ack = 1'b0;
      check_bit(fencei_flush_req, 1'b0, "flush request with access outstanding");
      check_bit(pc_set, 1'b0, "pc_set_o for ack without request");
    end
    bus_respond(1'b0);
    wait_for(EV_FLUSH_REQ, "flush request after response", seen);
    draw_bits(3, hold);
    repeat (hold + 1) begin
      step();
      check_bit(fencei_flush_req, 1'b1, "flush request held without ack");
    end
    fencei_flush_ack = 1'b1;
    step();
    fencei_flush_ack = 1'b0;
    check_bit(fencei_flush_req, 1'b0, "flush request after ack");
    check_bit(pc_set, 1'b1, "pc_set_o after ack");
    check_pc_mux(pc_mux, ctrl_pkg::PC_FENCEI, "pc_mux_o after ack");
    fencei_in_wb = 1'b0;
    step();
    check_bit(pc_set, 1'b0, "pc_set_o after fence.i restart");
  endtask

  task automatic test_nmi_vs_fencei();
    logic seen;
    lsu_in_wb = 1'b1;
    bus_accept(1'b1);
    bus_respond(1'b1);
    wait_for(EV_NMI_PENDING, "NMI pending before fence.i", seen);
    // Both become ready in the same cycle
    lsu_in_wb    = 1'b0;
    fencei_in_wb = 1'b1;
    wait_for(EV_PC_SET, "NMI trap against fence.i", seen);
    check_pc_mux(pc_mux, ctrl_pkg::PC_TRAP_NMI, "pc_mux_o with fence.i waiting");
    check_bit(fencei_flush_req, 1'b0, "flush request before NMI trap");
    check_bit(nmi_is_store, 1'b1, "nmi_is_store_o with fence.i waiting");
    wait_for(EV_FLUSH_REQ, "flush request after NMI trap", seen);
    fencei_flush_ack = 1'b1;
    step();
    fencei_flush_ack = 1'b0;
    check_bit(pc_set, 1'b1, "pc_set_o after late flush");
    check_pc_mux(pc_mux, ctrl_pkg::PC_FENCEI, "pc_mux_o after late flush");
    fencei_in_wb = 1'b0;
    step();
  endtask

  task automatic test_clean_traffic();
    int   outst;
    int   r;
    logic acc;
    logic rsp;
    outst = 0;
    for (int c = 0; c < 200; c++) begin
      draw_bits(1, r);
      obi_req = (r != 0) && (outst < MAX_OUTSTANDING);
      draw_bits(1, r);
      obi_gnt = (r != 0);
      draw_bits(1, r);
      obi_we = (r != 0);
      draw_bits(1, r);
      obi_rvalid = (r != 0) && (outst > 0);
      acc = obi_req && obi_gnt;
      rsp = obi_rvalid;
      step();
      outst = outst + int'(acc) - int'(rsp);
      check_bit(pc_set, 1'b0, "pc_set_o during clean traffic");
      check_bit(nmi_pending, 1'b0, "nmi_pending_o during clean traffic");
    end
    idle_inputs();
    while (outst > 0) begin
      bus_respond(1'b0);
      outst--;
    end
  endtask

`endif

//--- tb/tb_lsu_nmi_ctrl.sv
// Acts as an in-order bus master within MAX_OUTSTANDING; each wait gives up after WAIT_LIMIT cycles
`timescale 1ns/100ps

module tb_lsu_nmi_ctrl;

  localparam int MAX_OUTSTANDING = obi_pkg::MAX_OUTSTANDING_DEF;
  // Longest wait for any DUT event, in clock cycles
  localparam int WAIT_LIMIT      = 50;

  logic              clk;
  logic              rst_n;
  logic              obi_req;
  logic              obi_gnt;
  logic              obi_we;
  logic              obi_rvalid;
  logic              obi_err;
  logic              lsu_in_wb;
  logic              fencei_in_wb;
  logic              fencei_flush_ack;
  logic              fencei_flush_req;
  logic              pc_set;
  ctrl_pkg::pc_mux_e pc_mux;
  logic              nmi_pending;
  logic              nmi_is_store;

  // Result bookkeeping
  int                check_cnt;
  int                err_cnt;
  int                timeout_cnt;

  // State of the stimulus generator
  logic [15:0]       lfsr_q;

  ////////////////////
  // Clock and DUT
  ////////////////////

  initial clk = 1'b0;
  always #4 clk = ~clk;

  lsu_nmi_ctrl_top #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) lsu_nmi_ctrl_top_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .obi_req_i          (obi_req),
    .obi_gnt_i          (obi_gnt),
    .obi_we_i           (obi_we),
    .obi_rvalid_i       (obi_rvalid),
    .obi_err_i          (obi_err),
    .lsu_in_wb_i        (lsu_in_wb),
    .fencei_in_wb_i     (fencei_in_wb),
    .fencei_flush_ack_i (fencei_flush_ack),
    .fencei_flush_req_o (fencei_flush_req),
    .pc_set_o           (pc_set),
    .pc_mux_o           (pc_mux),
    .nmi_pending_o      (nmi_pending),
    .nmi_is_store_o     (nmi_is_store)
  );

  ////////////////////
  // Random bits
  ////////////////////

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Takes n bits, one LFSR step per bit, first bit ends up as the MSB
  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val    = (val << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  `include "tb_lsu_nmi_ctrl_tasks.svh"

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    lfsr_q      = 16'd77;
    check_cnt   = 0;
    err_cnt     = 0;
    timeout_cnt = 0;
    rst_n       = 1'b0;
    idle_inputs();
    repeat (8) @(posedge clk);
    #1;
    test_reset_values();
    rst_n = 1'b1;
    step();
    test_load_error();
    test_store_first();
    test_second_error();
    test_fencei_wait();
    test_nmi_vs_fencei();
    test_clean_traffic();
    $display("checks %0d, errors %0d, timeouts %0d", check_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
